// ==== common/sobel_pkg.sv ====
// Shared image sizes, data widths, thresholds and kernel weights
// Mode and kernel selection encodings for the Sobel pipeline
package sobel_pkg;

  localparam int unsigned ImgWidth    = 8;
  localparam int unsigned ImgHeight   = 6;
  localparam int unsigned KernelWidth = 3;
  localparam int unsigned KernelArea  = KernelWidth * KernelWidth;
  localparam int unsigned OutWidth    = ImgWidth - KernelWidth + 1;
  localparam int unsigned OutHeight   = ImgHeight - KernelWidth + 1;

  // Eight 1-bit pixels per byte
  localparam int unsigned BusWidth = 8;
  localparam int unsigned BytesIn  = ImgWidth * ImgHeight / BusWidth;
  localparam int unsigned BytesOut = (OutWidth * OutHeight + BusWidth - 1) / BusWidth;

  localparam int unsigned WeightWidth = 2;
  // Every tap set at weight magnitude 1, plus a sign bit
  localparam int unsigned ConvOutWidth = $clog2(KernelArea + 1) + 1;
  localparam int unsigned MagOutWidth  = ConvOutWidth + 1;

  typedef logic [BusWidth-1:0]            byte_t;
  typedef logic signed [ConvOutWidth-1:0] grad_t;
  typedef logic [MagOutWidth-1:0]         mag_t;
  typedef logic [KernelArea-1:0]          window_t;
  typedef logic signed [WeightWidth-1:0]  weight_t;

  typedef enum logic [1:0] {
    ModeMag  = 2'd0,
    ModeGx   = 2'd1,
    ModeGy   = 2'd2,
    ModeMag2 = 2'd3
  } mode_e;

  typedef enum logic {
    KernelGx = 1'b0,
    KernelGy = 1'b1
  } kernel_e;

  // Frame header, reused as the output tail
  localparam byte_t Hdr0 = 8'hA5;
  localparam byte_t Hdr1 = 8'h5A;

  localparam grad_t ConvThresh = grad_t'(2);
  localparam mag_t  MagThresh  = mag_t'(4);

  // Tap order is row * 3 + column, row 0 oldest
  localparam weight_t GxWeights [KernelArea] = '{
    2'sd1, 2'sd0, -2'sd1,
    2'sd1, 2'sd0, -2'sd1,
    2'sd1, 2'sd0, -2'sd1
  };

  localparam weight_t GyWeights [KernelArea] = '{
     2'sd1,  2'sd1,  2'sd1,
     2'sd0,  2'sd0,  2'sd0,
    -2'sd1, -2'sd1, -2'sd1
  };

endpackage

// ==== common/pix_stream_if.sv ====
// Window stream and gradient stream interfaces with their modports
`timescale 1ns/1ps

interface win_if;
  import sobel_pkg::*;

  logic    valid;
  // AND of the kernel readies below
  logic    ready;
  // One ready per kernel unit, indexed by kernel_e
  logic    [1:0] sink_ready;
  window_t taps;
  logic    last;

  modport source (output valid, taps, last, input ready);
  modport sink   (input valid, taps, last, ready, output sink_ready);

endinterface

interface grad_if;
  import sobel_pkg::*;

  logic  valid;
  logic  ready;
  grad_t grad;
  logic  last;

  modport source (output valid, grad, last, input ready);
  modport sink   (input valid, grad, last, output ready);

endinterface

// ==== design/framing/deframer.sv ====
// Header search and byte-to-pixel unpacking, LSB first
// Flags the final pixel of each frame
`timescale 1ns/1ps

module deframer (
   input  logic             clk_i
  ,input  logic             rst_n_i
  ,input  sobel_pkg::byte_t data_i
  ,input  logic             valid_i
  ,output logic             ready_o
  ,output logic             pix_o
  ,output logic             pix_valid_o
  ,input  logic             pix_ready_i
  ,output logic             pix_last_o
);
  import sobel_pkg::*;

  typedef enum logic [1:0] {StHdr0, StHdr1, StData} state_e;

  localparam int unsigned         ByteCntW    = $clog2(BytesIn);
  localparam logic [ByteCntW-1:0] ByteCntLast = ByteCntW'(BytesIn - 1);

  state_e              state_q;
  logic                ready_q;
  logic                full_q;
  logic                last_byte_q;
  logic [2:0]          pix_cnt_q;
  logic [ByteCntW-1:0] byte_cnt_q;
  byte_t               shift_q;
  logic                accept;
  logic                load;
  logic                pix_fire;
  logic                byte_done;

  assign accept    = valid_i && ready_q;
  assign load      = accept && (state_q == StData);
  assign pix_fire  = full_q && pix_ready_i;
  assign byte_done = pix_fire && (pix_cnt_q == 3'd7);

  assign ready_o     = ready_q;
  assign pix_valid_o = full_q;
  assign pix_o       = shift_q[0];
  assign pix_last_o  = last_byte_q && (pix_cnt_q == 3'd7);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= StHdr0;
      ready_q     <= 1'b0;
      full_q      <= 1'b0;
      last_byte_q <= 1'b0;
      pix_cnt_q   <= '0;
      byte_cnt_q  <= '0;
    end else begin
      // Ready only while the shift register is empty
      ready_q <= !load && (byte_done || !full_q);
      if (load) begin
        full_q <= 1'b1;
      end else if (byte_done) begin
        full_q <= 1'b0;
      end
      if (pix_fire) begin
        pix_cnt_q <= pix_cnt_q + 3'd1;
      end
      if (load && (byte_cnt_q == ByteCntLast)) begin
        last_byte_q <= 1'b1;
      end else if (byte_done) begin
        last_byte_q <= 1'b0;
      end
      if (accept) begin
        case (state_q)
          StHdr0: begin
            if (data_i == Hdr0) state_q <= StHdr1;
          end
          StHdr1: begin
            // A repeated A5 may still start the header
            if (data_i == Hdr1) begin
              state_q <= StData;
            end else if (data_i != Hdr0) begin
              state_q <= StHdr0;
            end
          end
          StData: begin
            if (byte_cnt_q == ByteCntLast) begin
              state_q    <= StHdr0;
              byte_cnt_q <= '0;
            end else begin
              byte_cnt_q <= byte_cnt_q + 1'b1;
            end
          end
          default: state_q <= StHdr0;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= data_i;
    end else if (pix_fire) begin
      shift_q <= {1'b0, shift_q[BusWidth-1:1]};
    end
  end

  a_pix_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pix_valid_o && !pix_ready_i |=> pix_valid_o && $stable(pix_o) && $stable(pix_last_o));

endmodule

// ==== design/framing/framer.sv ====
// Edge pixel to byte packing, LSB first, with A5 5A tail per frame
`timescale 1ns/1ps

module framer (
   input  logic             clk_i
  ,input  logic             rst_n_i
  ,input  logic             edge_i
  ,input  logic             edge_valid_i
  ,output logic             edge_ready_o
  ,input  logic             edge_last_i
  ,output sobel_pkg::byte_t data_o
  ,output logic             valid_o
  ,input  logic             ready_i
);
  import sobel_pkg::*;

  byte_t      acc_q;
  byte_t      acc_d;
  byte_t      data_q;
  logic [2:0] bit_cnt_q;
  // Tail bytes still to send
  logic [1:0] tail_cnt_q;
  logic       valid_q;
  logic       slot_free;
  logic       accept;
  logic       byte_full;

  assign slot_free    = !valid_q || ready_i;
  assign edge_ready_o = (tail_cnt_q == 2'd0) && slot_free;
  assign accept       = edge_valid_i && edge_ready_o;
  assign byte_full    = accept && ((bit_cnt_q == 3'd7) || edge_last_i);
  assign acc_d        = acc_q | (byte_t'(edge_i) << bit_cnt_q);

  assign data_o  = data_q;
  assign valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q      <= '0;
      bit_cnt_q  <= '0;
      tail_cnt_q <= '0;
      valid_q    <= 1'b0;
    end else begin
      if (byte_full) begin
        acc_q     <= '0;
        bit_cnt_q <= '0;
      end else if (accept) begin
        acc_q     <= acc_d;
        bit_cnt_q <= bit_cnt_q + 3'd1;
      end
      if (byte_full) begin
        valid_q <= 1'b1;
        if (edge_last_i) tail_cnt_q <= 2'd2;
      end else if ((tail_cnt_q != 2'd0) && slot_free) begin
        valid_q    <= 1'b1;
        tail_cnt_q <= tail_cnt_q - 2'd1;
      end else if (ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_full) begin
      data_q <= acc_d;
    end else if ((tail_cnt_q == 2'd2) && slot_free) begin
      data_q <= Hdr0;
    end else if ((tail_cnt_q == 2'd1) && slot_free) begin
      data_q <= Hdr1;
    end
  end

  a_data_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

// ==== design/conv/line_window.sv ====
// Two line buffers and a 3x3 window register
// Emits only windows that lie fully inside the image
`timescale 1ns/1ps

module line_window (
   input  logic  clk_i
  ,input  logic  rst_n_i
  ,input  logic  pix_i
  ,input  logic  pix_valid_i
  ,output logic  pix_ready_o
  ,input  logic  pix_last_i
  ,win_if.source win
);
  import sobel_pkg::*;

  localparam int unsigned     ColW        = $clog2(ImgWidth);
  localparam int unsigned     RowW        = $clog2(ImgHeight);
  localparam logic [ColW-1:0] ColLast     = ColW'(ImgWidth - 1);
  localparam logic [RowW-1:0] RowLast     = RowW'(ImgHeight - 1);
  localparam logic [ColW-1:0] ColFirstWin = ColW'(KernelWidth - 1);
  localparam logic [RowW-1:0] RowFirstWin = RowW'(KernelWidth - 1);

  // Row above the current one
  logic [ImgWidth-1:0] line1_q;
  // Two rows above
  logic [ImgWidth-1:0] line2_q;
  window_t             taps_q;
  logic [ColW-1:0]     col_q;
  logic [RowW-1:0]     row_q;
  logic                win_valid_q;
  logic                win_last_q;
  logic                accept;
  logic                at_end;
  logic                in_range;

  assign pix_ready_o = !win_valid_q || win.ready;
  assign accept      = pix_valid_i && pix_ready_o;
  assign at_end      = (col_q == ColLast) && (row_q == RowLast);
  assign in_range    = (col_q >= ColFirstWin) && (row_q >= RowFirstWin);

  assign win.valid = win_valid_q;
  assign win.taps  = taps_q;
  assign win.last  = win_last_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_q <= 1'b0;
      win_last_q  <= 1'b0;
    end else begin
      if (accept) begin
        if (at_end) begin
          col_q <= '0;
          row_q <= '0;
        end else if (col_q == ColLast) begin
          col_q <= '0;
          row_q <= row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
      if (accept && in_range) begin
        win_valid_q <= 1'b1;
        win_last_q  <= at_end;
      end else if (win_valid_q && win.ready) begin
        win_valid_q <= 1'b0;
      end
    end
  end

  // Shift the window left and bring in the newest column
  always_ff @(posedge clk_i) begin
    if (accept) begin
      line2_q[col_q] <= line1_q[col_q];
      line1_q[col_q] <= pix_i;
      for (int r = 0; r < KernelWidth; r++) begin
        for (int c = 0; c < KernelWidth - 1; c++) begin
          taps_q[r*KernelWidth+c] <= taps_q[r*KernelWidth+c+1];
        end
      end
      taps_q[KernelWidth-1]          <= line2_q[col_q];
      taps_q[2*KernelWidth-1]        <= line1_q[col_q];
      taps_q[KernelWidth*KernelWidth-1] <= pix_i;
    end
  end

  // Deframer end of frame must line up with the raster position
  a_last_pos : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pix_valid_i && pix_last_i |-> at_end);

endmodule

// ==== design/conv/kernel_mac.sv ====
// Signed weighted sum of a 3x3 binary window against a fixed kernel
`timescale 1ns/1ps

module kernel_mac #(
  parameter sobel_pkg::kernel_e Kernel = sobel_pkg::KernelGx
) (
   input  logic   clk_i
  ,input  logic   rst_n_i
  ,win_if.sink    win
  ,grad_if.source grad
);
  import sobel_pkg::*;

  grad_t sum;
  grad_t grad_q;
  logic  valid_q;
  logic  last_q;
  logic  take;

  // Own ready, combined with the other kernel at the top
  assign win.sink_ready[Kernel] = !valid_q || grad.ready;
  assign take = win.valid && win.ready;

  assign grad.valid = valid_q;
  assign grad.grad  = grad_q;
  assign grad.last  = last_q;

  // Pixels are 1 bit, so each set tap adds its weight
  always_comb begin
    sum = '0;
    for (int i = 0; i < KernelArea; i++) begin
      if (win.taps[i]) begin
        sum = sum + grad_t'((Kernel == KernelGx) ? GxWeights[i] : GyWeights[i]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
      last_q  <= win.last;
    end else if (grad.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) grad_q <= sum;
  end

  a_grad_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    grad.valid && !grad.ready |=> grad.valid && $stable(grad.grad) && $stable(grad.last));

endmodule

// ==== design/edge_combine.sv ====
// Gradient magnitude, thresholds and mode selection
// Produces one registered edge pixel per Gx/Gy pair
`timescale 1ns/1ps

module edge_combine (
   input  logic             clk_i
  ,input  logic             rst_n_i
  ,input  sobel_pkg::mode_e mode_i
  ,grad_if.sink             gx
  ,grad_if.sink             gy
  ,output logic             edge_o
  ,output logic             edge_valid_o
  ,input  logic             edge_ready_i
  ,output logic             edge_last_o
);
  import sobel_pkg::*;

  mag_t abs_gx;
  mag_t abs_gy;
  mag_t mag;
  logic gx_edge;
  logic gy_edge;
  logic mag_edge;
  logic sel_edge;
  logic edge_q;
  logic valid_q;
  logic last_q;
  logic slot_free;
  logic take;

  assign slot_free = !valid_q || edge_ready_i;
  // Both gradients move together
  assign take      = gx.valid && gy.valid && slot_free;
  assign gx.ready  = take;
  assign gy.ready  = take;

  assign abs_gx = gx.grad[ConvOutWidth-1] ? mag_t'(-gx.grad) : mag_t'(gx.grad);
  assign abs_gy = gy.grad[ConvOutWidth-1] ? mag_t'(-gy.grad) : mag_t'(gy.grad);
  assign mag    = abs_gx + abs_gy;

  assign gx_edge  = gx.grad >= ConvThresh;
  assign gy_edge  = gy.grad >= ConvThresh;
  assign mag_edge = mag >= MagThresh;

  always_comb begin
    case (mode_i)
      ModeGx:   sel_edge = gx_edge;
      ModeGy:   sel_edge = gy_edge;
      ModeMag:  sel_edge = mag_edge;
      ModeMag2: sel_edge = mag_edge;
    endcase
  end

  assign edge_o       = edge_q;
  assign edge_valid_o = valid_q;
  assign edge_last_o  = last_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
      last_q  <= gx.last;
    end else if (edge_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) edge_q <= sel_edge;
  end

  // Kernel units must stay in lockstep
  a_lockstep : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gx.valid == gy.valid) && (!gx.valid || (gx.last == gy.last)));

endmodule

// ==== design/sobel_edge_top.sv ====
// Sobel edge pipeline from framed input bytes to framed edge bytes
`timescale 1ns/1ps

module sobel_edge_top (
   input  logic             clk_i
  ,input  logic             rst_n_i
  ,input  sobel_pkg::mode_e mode_i
  ,input  sobel_pkg::byte_t data_i
  ,input  logic             valid_i
  ,output logic             ready_o
  ,output sobel_pkg::byte_t data_o
  ,output logic             valid_o
  ,input  logic             ready_i
);
  import sobel_pkg::*;

  logic pix;
  logic pix_valid;
  logic pix_ready;
  logic pix_last;
  logic edge_pix;
  logic edge_valid;
  logic edge_ready;
  logic edge_last;

  win_if  win_bus ();
  grad_if gx_bus ();
  grad_if gy_bus ();

  // Window leaves only when both kernels can take it
  assign win_bus.ready = win_bus.sink_ready[KernelGx] & win_bus.sink_ready[KernelGy];

  deframer u_deframer (
     .clk_i      (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.data_i     (data_i)
    ,.valid_i    (valid_i)
    ,.ready_o    (ready_o)
    ,.pix_o      (pix)
    ,.pix_valid_o(pix_valid)
    ,.pix_ready_i(pix_ready)
    ,.pix_last_o (pix_last)
  );

  line_window u_line_window (
     .clk_i      (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.pix_i      (pix)
    ,.pix_valid_i(pix_valid)
    ,.pix_ready_o(pix_ready)
    ,.pix_last_i (pix_last)
    ,.win        (win_bus)
  );

  kernel_mac #(.Kernel(KernelGx)) u_gx (
     .clk_i  (clk_i)
    ,.rst_n_i(rst_n_i)
    ,.win    (win_bus)
    ,.grad   (gx_bus)
  );

  kernel_mac #(.Kernel(KernelGy)) u_gy (
     .clk_i  (clk_i)
    ,.rst_n_i(rst_n_i)
    ,.win    (win_bus)
    ,.grad   (gy_bus)
  );

  edge_combine u_edge_combine (
     .clk_i       (clk_i)
    ,.rst_n_i     (rst_n_i)
    ,.mode_i      (mode_i)
    ,.gx          (gx_bus)
    ,.gy          (gy_bus)
    ,.edge_o      (edge_pix)
    ,.edge_valid_o(edge_valid)
    ,.edge_ready_i(edge_ready)
    ,.edge_last_o (edge_last)
  );

  framer u_framer (
     .clk_i       (clk_i)
    ,.rst_n_i     (rst_n_i)
    ,.edge_i      (edge_pix)
    ,.edge_valid_i(edge_valid)
    ,.edge_ready_o(edge_ready)
    ,.edge_last_i (edge_last)
    ,.data_o      (data_o)
    ,.valid_o     (valid_o)
    ,.ready_i     (ready_i)
  );

endmodule

// ==== verification/tb_sobel_edge.sv ====
// Testbench for the Sobel edge pipeline, driven from a case file
// Random valid gaps and ready stalls, byte and count checks, watchdog
`timescale 1ns/1ps

module tb_sobel_edge;
  import sobel_pkg::*;

  // Edge bytes plus the two tail bytes
  localparam int          ExpPerCase    = BytesOut + 2;
  localparam int          MinFields     = 1 + 2 + BytesIn + ExpPerCase;
  localparam int          CyclesPerCase = 400;
  localparam int unsigned RandSeed      = 32'h92d76cc2;

  logic  clk_i;
  logic  rst_n_i;
  mode_e mode_i;
  byte_t data_i;
  logic  valid_i;
  logic  ready_o;
  byte_t data_o;
  logic  valid_o;
  logic  ready_i;

  // Hex tokens of the line being parsed
  int    fields[$];
  int    case_mode[$];
  int    in_start[$];
  int    in_len[$];
  byte_t in_bytes[$];
  byte_t exp_bytes[$];
  logic  cases_loaded;

  sobel_edge_top uut (
     .clk_i  (clk_i)
    ,.rst_n_i(rst_n_i)
    ,.mode_i (mode_i)
    ,.data_i (data_i)
    ,.valid_i(valid_i)
    ,.ready_o(ready_o)
    ,.data_o (data_o)
    ,.valid_o(valid_o)
    ,.ready_i(ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  function automatic int hex_digit(input int c);
    if (c >= int'("0") && c <= int'("9")) return c - int'("0");
    if (c >= int'("a") && c <= int'("f")) return c - int'("a") + 10;
    if (c >= int'("A") && c <= int'("F")) return c - int'("A") + 10;
    return -1;
  endfunction

  // Splits a line into hex numbers, ignoring anything after '#'
  function automatic void split_hex(input string line);
    int val;
    int digit;
    bit in_tok;
    fields.delete();
    val    = 0;
    in_tok = 1'b0;
    for (int i = 0; i < line.len(); i++) begin
      if (int'(line.getc(i)) == int'("#")) break;
      digit = hex_digit(int'(line.getc(i)));
      if (digit >= 0) begin
        val    = val * 16 + digit;
        in_tok = 1'b1;
      end else begin
        if (in_tok) fields.push_back(val);
        val    = 0;
        in_tok = 1'b0;
      end
    end
    if (in_tok) fields.push_back(val);
  endfunction

  // Mode first, expected bytes last, input bytes in between
  task automatic load_cases();
    int    fd;
    int    n;
    string line;
    fd = $fopen("verification/edge_cases.txt", "r");
    if (fd == 0) abort_run("Could not open verification/edge_cases.txt");
    while ($fgets(line, fd) != 0) begin
      split_hex(line);
      n = fields.size();
      if (n == 0) continue;
      if (n < MinFields) abort_run($sformatf("Malformed case line: %s", line));
      case_mode.push_back(fields[0]);
      in_start.push_back(in_bytes.size());
      in_len.push_back(n - 1 - ExpPerCase);
      for (int i = 1; i < n - ExpPerCase; i++) begin
        in_bytes.push_back(byte_t'(fields[i]));
      end
      for (int i = n - ExpPerCase; i < n; i++) begin
        exp_bytes.push_back(byte_t'(fields[i]));
      end
    end
    $fclose(fd);
    if (case_mode.size() == 0) abort_run("No cases found in the case file");
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_byte(input byte_t b);
    bit ok;
    while ($urandom_range(0, 3) == 0) begin
      valid_i = 1'b0;
      @(negedge clk_i);
    end
    data_i  = b;
    valid_i = 1'b1;
    ok      = 1'b0;
    while (!ok) begin
      ok = ready_o;
      @(negedge clk_i);
    end
  endtask

  task automatic send_frame(input int k);
    for (int i = 0; i < in_len[k]; i++) begin
      send_byte(in_bytes[in_start[k] + i]);
    end
    valid_i = 1'b0;
  endtask

  // Collects bytes until the A5 5A tail shows up, then checks the frame
  task automatic receive_frame(input int k);
    byte_t got[$];
    bit    done;
    int    n;
    done = 1'b0;
    while (!done) begin
      ready_i = ($urandom_range(0, 3) != 0);
      if (valid_o && ready_i) begin
        got.push_back(data_o);
        n    = got.size();
        done = (n >= 2) && (got[n-2] == Hdr0) && (got[n-1] == Hdr1);
      end
      @(negedge clk_i);
    end
    ready_i = 1'b0;
    check_count($sformatf("data_o byte count case %0d", k), got.size(), ExpPerCase);
    for (int i = 0; i < ExpPerCase; i++) begin
      check_byte($sformatf("data_o case %0d byte %0d", k, i), got[i],
                 exp_bytes[k * ExpPerCase + i]);
    end
  endtask

  // Pipeline is empty here, so the mode can change safely
  task automatic run_case(input int k);
    mode_i = mode_e'(case_mode[k]);
    fork
      send_frame(k);
      receive_frame(k);
    join
  endtask

  initial begin : main_seq
    void'($urandom(RandSeed));
    rst_n_i      = 1'b0;
    mode_i       = ModeMag;
    data_i       = '0;
    valid_i      = 1'b0;
    ready_i      = 1'b0;
    cases_loaded = 1'b0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int k = 0; k < case_mode.size(); k++) begin
      run_case(k);
    end
    $display("all tests passed");
    $finish;
  end

  initial begin : watchdog
    wait (cases_loaded);
    repeat (case_mode.size() * CyclesPerCase) @(posedge clk_i);
    abort_run($sformatf("Timeout: run still busy after %0d cycles",
                        case_mode.size() * CyclesPerCase));
  end

endmodule

// ==== verification/edge_cases.txt ====
# mode (0 mag, 1 gx, 2 gy, 3 mag), input bytes (junk, A5 5A, 6 rows LSB first),
# then 5 expected output bytes (3 edge bytes, A5 5A tail), all hex
0  A5 5A 00 00 00 00 00 00   00 00 00 A5 5A
1  A5 5A 00 00 00 00 00 00   00 00 00 A5 5A
2  A5 5A 00 00 00 00 00 00   00 00 00 A5 5A
3  A5 5A 00 00 00 00 00 00   00 00 00 A5 5A
0  A5 5A FF FF FF FF FF FF   00 00 00 A5 5A
1  A5 5A FF FF FF FF FF FF   00 00 00 A5 5A
2  A5 5A FF FF FF FF FF FF   00 00 00 A5 5A
3  A5 5A FF FF FF FF FF FF   00 00 00 A5 5A
1  A5 5A 0F 0F 0F 0F 0F 0F   0C C3 30 A5 5A  # vertical stripe
2  A5 5A 0F 0F 0F 0F 0F 0F   00 00 00 A5 5A
0  A5 5A 0F 0F 0F 0F 0F 0F   00 00 00 A5 5A
1  A5 5A 3C 3C 3C 3C 3C 3C   30 0C C3 A5 5A
2  A5 5A FF FF FF 00 00 00   C0 FF 03 A5 5A  # horizontal stripe
1  A5 5A FF FF FF 00 00 00   00 00 00 A5 5A
0  A5 5A FF FF FF 00 00 00   00 00 00 A5 5A
0  A5 5A 0F 0F 0F 00 00 00   00 01 00 A5 5A  # top left block
3  A5 5A 0F 0F 0F 00 00 00   00 01 00 A5 5A
1  A5 5A 0F 0F 0F 00 00 00   0C 03 00 A5 5A
2  A5 5A 0F 0F 0F 00 00 00   C0 71 00 A5 5A
0  A5 5A 00 00 00 F0 F0 F0   00 80 00 A5 5A  # bottom right block
1  A5 5A 00 00 00 F0 F0 F0   00 00 00 A5 5A
3  A5 5A 00 00 00 F0 F0 F0   00 80 00 A5 5A
1  00 A5 33 12 A5 5A 0F 0F 0F 0F 0F 0F   0C C3 30 A5 5A
0  A5 A5 A5 5A 0F 0F 0F 00 00 00   00 01 00 A5 5A
2  5A FF A5 00 A5 5A FF FF FF 00 00 00   C0 FF 03 A5 5A

// ==== src.f ====
common/sobel_pkg.sv
common/pix_stream_if.sv
design/framing/deframer.sv
design/framing/framer.sv
design/conv/line_window.sv
design/conv/kernel_mac.sv
design/edge_combine.sv
design/sobel_edge_top.sv
verification/tb_sobel_edge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the Sobel edge testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_sobel_edge \
  -Mdir obj_dir \
  -f src.f

./obj_dir/Vtb_sobel_edge
